//--- source/exec_pkg.sv
//////////////////////////////
// machine-mode encodings only
// CSR addresses per the privileged spec
//////////////////////////////

package exec_pkg;

  // decoded instruction opcodes
  typedef enum logic [4:0] {
    op_nop,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_sra,
    op_slt,
    op_sltu,
    op_beq,
    op_bne,
    op_blt,
    op_bge,
    op_jal,
    op_jalr,
    op_csrrw,
    op_csrrs,
    op_csrrc,
    op_ecall,
    op_mret
  } exec_op_e;

  // trap FSM steps
  typedef enum logic [2:0] {
    trap_idle,
    trap_wr_epc,
    trap_wr_cause,
    trap_wr_status,
    trap_done
  } trap_state_e;

  localparam logic [11:0] csr_mstatus  = 12'h300;
  localparam logic [11:0] csr_mie      = 12'h304;
  localparam logic [11:0] csr_mtvec    = 12'h305;
  localparam logic [11:0] csr_mscratch = 12'h340;
  localparam logic [11:0] csr_mepc     = 12'h341;
  localparam logic [11:0] csr_mcause   = 12'h342;

  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;
  localparam int mie_mtie_bit     = 7;

  // exception codes without the interrupt flag
  localparam logic [3:0] cause_ecall_m = 4'd11;
  localparam logic [3:0] cause_timer_m = 4'd7;

endpackage

//--- source/exec_unit.sv
//////////////////////////////
// purely combinational without a path enable
//////////////////////////////

`timescale 1ns/10ps

module exec_unit #(
  parameter int XLEN = 64
) (
  input  exec_pkg::exec_op_e i_op,
  input  logic [XLEN-1:0]    i_pc,
  input  logic [XLEN-1:0]    i_op1,
  input  logic [XLEN-1:0]    i_op2,
  input  logic [XLEN-1:0]    i_op3,
  input  logic [11:0]        i_csr_addr,
  input  logic [XLEN-1:0]    i_csr_rdata,
  output logic               o_csr_ren,
  output logic               o_csr_wen,
  output logic [XLEN-1:0]    o_csr_wdata,
  output logic               o_jmp,
  output logic [XLEN-1:0]    o_jmp_addr,
  output logic [XLEN-1:0]    o_rd_wdata
);

  localparam int sh_w = $clog2(XLEN);

  logic [sh_w-1:0] shamt;
  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic [XLEN-1:0] link;
  logic [XLEN-1:0] br_target;
  logic [XLEN-1:0] jmp_target;
  logic            is_csr;
  logic            csr_writable;
  logic [XLEN-1:0] csr_new;

  assign shamt      = i_op2[sh_w-1:0];
  assign eq         = (i_op1 == i_op2);
  assign lt_s       = ($signed(i_op1) < $signed(i_op2));
  assign lt_u       = (i_op1 < i_op2);
  assign link       = i_pc + XLEN'(4);
  assign br_target  = i_pc + i_op3;
  assign jmp_target = (i_op1 + i_op2) & ~XLEN'(1);

  assign is_csr = i_op inside {exec_pkg::op_csrrw, exec_pkg::op_csrrs, exec_pkg::op_csrrc};
  // top two address bits 11 mark a read-only CSR
  assign csr_writable = (i_csr_addr[11:10] != 2'b11);

  always_comb begin
    case (i_op)
      exec_pkg::op_csrrw: csr_new = i_op1;
      exec_pkg::op_csrrs: csr_new = i_csr_rdata | i_op1;
      exec_pkg::op_csrrc: csr_new = i_csr_rdata & ~i_op1;
      default:            csr_new = '0;
    endcase
  end

  assign o_csr_ren   = is_csr;
  assign o_csr_wen   = is_csr & csr_writable;
  assign o_csr_wdata = csr_new;

  always_comb begin
    o_jmp      = 1'b0;
    o_jmp_addr = '0;
    o_rd_wdata = '0;
    case (i_op)
      exec_pkg::op_add:  o_rd_wdata = i_op1 + i_op2;
      exec_pkg::op_sub:  o_rd_wdata = i_op1 - i_op2;
      exec_pkg::op_and:  o_rd_wdata = i_op1 & i_op2;
      exec_pkg::op_or:   o_rd_wdata = i_op1 | i_op2;
      exec_pkg::op_xor:  o_rd_wdata = i_op1 ^ i_op2;
      exec_pkg::op_sll:  o_rd_wdata = i_op1 << shamt;
      exec_pkg::op_srl:  o_rd_wdata = i_op1 >> shamt;
      exec_pkg::op_sra:  o_rd_wdata = $unsigned($signed(i_op1) >>> shamt);
      exec_pkg::op_slt:  o_rd_wdata = XLEN'(lt_s);
      exec_pkg::op_sltu: o_rd_wdata = XLEN'(lt_u);
      exec_pkg::op_beq,
      exec_pkg::op_bne,
      exec_pkg::op_blt,
      exec_pkg::op_bge: begin
        o_jmp_addr = br_target;
        case (i_op)
          exec_pkg::op_beq: o_jmp = eq;
          exec_pkg::op_bne: o_jmp = ~eq;
          exec_pkg::op_blt: o_jmp = lt_s;
          default:          o_jmp = ~lt_s;
        endcase
      end
      exec_pkg::op_jal,
      exec_pkg::op_jalr: begin
        o_jmp      = 1'b1;
        o_jmp_addr = jmp_target;
        o_rd_wdata = link;
      end
      exec_pkg::op_csrrw,
      exec_pkg::op_csrrs,
      exec_pkg::op_csrrc: o_rd_wdata = i_csr_rdata;
      default: ;
    endcase
  end

endmodule

//--- source/trap_unit.sv
//////////////////////////////
// i_start is the acceptance pulse
// target is read after the writes
//////////////////////////////

`timescale 1ns/10ps

module trap_unit #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_start,
  input  logic            i_is_mret,
  input  logic            i_is_intr,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_csr_rdata,
  output logic [11:0]     o_csr_addr,
  output logic            o_csr_wen,
  output logic [XLEN-1:0] o_csr_wdata,
  output logic [XLEN-1:0] o_jmp_addr,
  output logic            o_done
);

  exec_pkg::trap_state_e state_q;
  exec_pkg::trap_state_e state_d;

  logic            is_mret_q;
  logic            is_intr_q;
  logic [XLEN-1:0] jmp_addr_q;
  logic [XLEN-1:0] cause_code;
  logic [XLEN-1:0] cause_val;
  logic [XLEN-1:0] status_enter;
  logic [XLEN-1:0] status_leave;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= exec_pkg::trap_idle;
      is_mret_q <= 1'b0;
      is_intr_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (i_start) begin
        is_mret_q <= i_is_mret;
        is_intr_q <= i_is_intr;
      end
    end
  end

  always_comb begin
    case (state_q)
      exec_pkg::trap_idle: begin
        if (i_start) begin
          state_d = i_is_mret ? exec_pkg::trap_wr_status : exec_pkg::trap_wr_epc;
        end else begin
          state_d = exec_pkg::trap_idle;
        end
      end
      exec_pkg::trap_wr_epc:    state_d = exec_pkg::trap_wr_cause;
      exec_pkg::trap_wr_cause:  state_d = exec_pkg::trap_wr_status;
      exec_pkg::trap_wr_status: state_d = exec_pkg::trap_done;
      default:                  state_d = exec_pkg::trap_idle;
    endcase
  end

  // interrupt flag sits in the top bit
  assign cause_code = is_intr_q ? XLEN'(exec_pkg::cause_timer_m) : XLEN'(exec_pkg::cause_ecall_m);
  assign cause_val  = {is_intr_q, cause_code[XLEN-2:0]};

  always_comb begin
    status_enter = i_csr_rdata;
    status_enter[exec_pkg::mstatus_mpie_bit] = i_csr_rdata[exec_pkg::mstatus_mie_bit];
    status_enter[exec_pkg::mstatus_mie_bit]  = 1'b0;
    status_leave = i_csr_rdata;
    status_leave[exec_pkg::mstatus_mie_bit]  = i_csr_rdata[exec_pkg::mstatus_mpie_bit];
    status_leave[exec_pkg::mstatus_mpie_bit] = 1'b1;
  end

  always_comb begin
    o_csr_wen   = 1'b1;
    o_csr_wdata = '0;
    case (state_q)
      exec_pkg::trap_wr_epc: begin
        o_csr_addr  = exec_pkg::csr_mepc;
        o_csr_wdata = i_pc;
      end
      exec_pkg::trap_wr_cause: begin
        o_csr_addr  = exec_pkg::csr_mcause;
        o_csr_wdata = cause_val;
      end
      exec_pkg::trap_wr_status: begin
        o_csr_addr  = exec_pkg::csr_mstatus;
        o_csr_wdata = is_mret_q ? status_leave : status_enter;
      end
      default: begin
        // read back the jump target
        o_csr_addr = is_mret_q ? exec_pkg::csr_mepc : exec_pkg::csr_mtvec;
        o_csr_wen  = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (state_q == exec_pkg::trap_done) begin
      jmp_addr_q <= i_csr_rdata;
    end
  end

  assign o_jmp_addr = jmp_addr_q;
  assign o_done     = (state_q == exec_pkg::trap_done);

endmodule

//--- source/csr_file.sv
//////////////////////////////
// six machine CSRs, one port
// unknown addresses read 0
//////////////////////////////

`timescale 1ns/10ps

module csr_file #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rst,
  input  logic [11:0]     i_addr,
  input  logic            i_ren,
  input  logic            i_wen,
  input  logic [XLEN-1:0] i_wdata,
  output logic [XLEN-1:0] o_rdata,
  output logic            o_mstatus_mie,
  output logic            o_mie_mtie
);

  // only MIE and MPIE are implemented in mstatus
  localparam logic [XLEN-1:0] mstatus_mask =
    (XLEN'(1) << exec_pkg::mstatus_mie_bit) | (XLEN'(1) << exec_pkg::mstatus_mpie_bit);

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mie;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] mscratch;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus  <= '0;
      mie      <= '0;
      mtvec    <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mscratch <= '0;
    end else if (i_wen) begin
      case (i_addr)
        exec_pkg::csr_mstatus:  mstatus  <= i_wdata & mstatus_mask;
        exec_pkg::csr_mie:      mie      <= i_wdata;
        exec_pkg::csr_mtvec:    mtvec    <= i_wdata;
        exec_pkg::csr_mepc:     mepc     <= i_wdata;
        exec_pkg::csr_mcause:   mcause   <= i_wdata;
        exec_pkg::csr_mscratch: mscratch <= i_wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    o_rdata = '0;
    if (i_ren) begin
      case (i_addr)
        exec_pkg::csr_mstatus:  o_rdata = mstatus;
        exec_pkg::csr_mie:      o_rdata = mie;
        exec_pkg::csr_mtvec:    o_rdata = mtvec;
        exec_pkg::csr_mepc:     o_rdata = mepc;
        exec_pkg::csr_mcause:   o_rdata = mcause;
        exec_pkg::csr_mscratch: o_rdata = mscratch;
        default: ;
      endcase
    end
  end

  // interrupt enables for the stage
  assign o_mstatus_mie = mstatus[exec_pkg::mstatus_mie_bit];
  assign o_mie_mtie    = mie[exec_pkg::mie_mtie_bit];

endmodule

//--- source/exe_stage.sv
//////////////////////////////
// one instruction at a time
// results held until i_exe_ack
//////////////////////////////

`timescale 1ns/10ps

module exe_stage #(
  parameter int XLEN = 64
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_dec_req,
  output logic               o_dec_ack,
  input  exec_pkg::exec_op_e i_dec_op,
  input  logic [XLEN-1:0]    i_dec_pc,
  input  logic [XLEN-1:0]    i_dec_op1,
  input  logic [XLEN-1:0]    i_dec_op2,
  input  logic [XLEN-1:0]    i_dec_op3,
  input  logic [11:0]        i_dec_csr_addr,
  input  logic [4:0]         i_dec_rd,
  input  logic               i_dec_rd_wen,
  input  logic               i_exe_ack,
  input  logic               i_mtime_overflow,
  output logic               o_exe_req,
  output logic [XLEN-1:0]    o_exe_pc,
  output logic [4:0]         o_exe_rd,
  output logic               o_exe_rd_wen,
  output logic [XLEN-1:0]    o_exe_rd_wdata,
  output logic               o_exe_jmp,
  output logic [XLEN-1:0]    o_exe_jmp_addr,
  output logic [3:0]         o_exe_intr_no,
  input  logic               i_mstatus_mie,
  input  logic               i_mie_mtie,
  input  logic [XLEN-1:0]    i_csr_rdata,
  output logic [11:0]        o_csr_addr,
  output logic               o_csr_ren,
  output logic               o_csr_wen,
  output logic [XLEN-1:0]    o_csr_wdata
);

  logic               busy_q;
  logic               req_q;
  logic               trap_sel_q;
  logic [3:0]         intr_no_q;
  exec_pkg::exec_op_e op_q;
  logic [XLEN-1:0]    pc_q;
  logic [XLEN-1:0]    op1_q;
  logic [XLEN-1:0]    op2_q;
  logic [XLEN-1:0]    op3_q;
  logic [11:0]        csr_addr_q;
  logic [4:0]         rd_q;
  logic               rd_wen_q;

  logic dec_hs;
  logic exe_hs;
  logic intr_pend;
  logic to_trap;

  logic            ex_csr_ren;
  logic            ex_csr_wen;
  logic [XLEN-1:0] ex_csr_wdata;
  logic            ex_jmp;
  logic [XLEN-1:0] ex_jmp_addr;
  logic [XLEN-1:0] ex_rd_wdata;
  logic [11:0]     tr_csr_addr;
  logic            tr_csr_wen;
  logic [XLEN-1:0] tr_csr_wdata;
  logic [XLEN-1:0] tr_jmp_addr;
  logic            tr_done;

  assign o_dec_ack = ~busy_q;
  assign dec_hs    = i_dec_req & o_dec_ack;
  assign exe_hs    = req_q & i_exe_ack;
  assign intr_pend = i_mtime_overflow & i_mstatus_mie & i_mie_mtie;
  // interrupt wins over the instruction
  assign to_trap   = intr_pend | (i_dec_op == exec_pkg::op_ecall) |
                     (i_dec_op == exec_pkg::op_mret);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q     <= 1'b0;
      req_q      <= 1'b0;
      trap_sel_q <= 1'b0;
      intr_no_q  <= '0;
    end else if (dec_hs) begin
      busy_q     <= 1'b1;
      trap_sel_q <= to_trap;
      req_q      <= ~to_trap;
      intr_no_q  <= intr_pend ? 4'd7 : 4'd0;
    end else if (exe_hs) begin
      busy_q    <= 1'b0;
      req_q     <= 1'b0;
      intr_no_q <= '0;
    end else if (tr_done) begin
      req_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_hs) begin
      op_q       <= i_dec_op;
      pc_q       <= i_dec_pc;
      op1_q      <= i_dec_op1;
      op2_q      <= i_dec_op2;
      op3_q      <= i_dec_op3;
      csr_addr_q <= i_dec_csr_addr;
      rd_q       <= i_dec_rd;
      rd_wen_q   <= i_dec_rd_wen;
    end
  end

  exec_unit #(.XLEN(XLEN)) u_exec_unit (
    .i_op        (op_q),
    .i_pc        (pc_q),
    .i_op1       (op1_q),
    .i_op2       (op2_q),
    .i_op3       (op3_q),
    .i_csr_addr  (csr_addr_q),
    .i_csr_rdata (i_csr_rdata),
    .o_csr_ren   (ex_csr_ren),
    .o_csr_wen   (ex_csr_wen),
    .o_csr_wdata (ex_csr_wdata),
    .o_jmp       (ex_jmp),
    .o_jmp_addr  (ex_jmp_addr),
    .o_rd_wdata  (ex_rd_wdata)
  );

  trap_unit #(.XLEN(XLEN)) u_trap_unit (
    .clk         (clk),
    .rst         (rst),
    .i_start     (dec_hs & to_trap),
    .i_is_mret   ((i_dec_op == exec_pkg::op_mret) & ~intr_pend),
    .i_is_intr   (intr_pend),
    .i_pc        (pc_q),
    .i_csr_rdata (i_csr_rdata),
    .o_csr_addr  (tr_csr_addr),
    .o_csr_wen   (tr_csr_wen),
    .o_csr_wdata (tr_csr_wdata),
    .o_jmp_addr  (tr_jmp_addr),
    .o_done      (tr_done)
  );

  // exec path writes its CSR once on the handshake edge
  assign o_csr_addr  = trap_sel_q ? tr_csr_addr : csr_addr_q;
  assign o_csr_ren   = busy_q & (trap_sel_q | ex_csr_ren);
  assign o_csr_wen   = trap_sel_q ? tr_csr_wen : (ex_csr_wen & exe_hs);
  assign o_csr_wdata = trap_sel_q ? tr_csr_wdata : ex_csr_wdata;

  assign o_exe_req      = req_q;
  assign o_exe_pc       = pc_q;
  assign o_exe_rd       = rd_q;
  assign o_exe_rd_wen   = busy_q & ~trap_sel_q & rd_wen_q;
  assign o_exe_rd_wdata = trap_sel_q ? '0 : ex_rd_wdata;
  assign o_exe_jmp      = busy_q & (trap_sel_q | ex_jmp);
  assign o_exe_jmp_addr = trap_sel_q ? tr_jmp_addr : ex_jmp_addr;
  assign o_exe_intr_no  = intr_no_q;

endmodule

//--- source/execute_core.sv
//////////////////////////////
// XLEN is 64 or 32
//////////////////////////////

`timescale 1ns/10ps

module execute_core #(
  parameter int XLEN = 64
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_dec_req,
  input  exec_pkg::exec_op_e i_dec_op,
  input  logic [XLEN-1:0]    i_dec_pc,
  input  logic [XLEN-1:0]    i_dec_op1,
  input  logic [XLEN-1:0]    i_dec_op2,
  input  logic [XLEN-1:0]    i_dec_op3,
  input  logic [11:0]        i_dec_csr_addr,
  input  logic [4:0]         i_dec_rd,
  input  logic               i_dec_rd_wen,
  input  logic               i_exe_ack,
  input  logic               i_mtime_overflow,
  output logic               o_dec_ack,
  output logic               o_exe_req,
  output logic [XLEN-1:0]    o_exe_pc,
  output logic [4:0]         o_exe_rd,
  output logic               o_exe_rd_wen,
  output logic [XLEN-1:0]    o_exe_rd_wdata,
  output logic               o_exe_jmp,
  output logic [XLEN-1:0]    o_exe_jmp_addr,
  output logic [3:0]         o_exe_intr_no
);

  logic [11:0]     csr_addr;
  logic            csr_ren;
  logic            csr_wen;
  logic [XLEN-1:0] csr_wdata;
  logic [XLEN-1:0] csr_rdata;
  logic            mstatus_mie;
  logic            mie_mtie;

  exe_stage #(.XLEN(XLEN)) u_exe_stage (
    .clk (clk), .rst (rst),
    .i_dec_req (i_dec_req), .o_dec_ack (o_dec_ack), .i_dec_op (i_dec_op),
    .i_dec_pc (i_dec_pc), .i_dec_op1 (i_dec_op1), .i_dec_op2 (i_dec_op2),
    .i_dec_op3 (i_dec_op3), .i_dec_csr_addr (i_dec_csr_addr),
    .i_dec_rd (i_dec_rd), .i_dec_rd_wen (i_dec_rd_wen),
    .i_exe_ack (i_exe_ack), .i_mtime_overflow (i_mtime_overflow),
    .o_exe_req (o_exe_req), .o_exe_pc (o_exe_pc), .o_exe_rd (o_exe_rd),
    .o_exe_rd_wen (o_exe_rd_wen), .o_exe_rd_wdata (o_exe_rd_wdata),
    .o_exe_jmp (o_exe_jmp), .o_exe_jmp_addr (o_exe_jmp_addr),
    .o_exe_intr_no (o_exe_intr_no),
    .i_mstatus_mie (mstatus_mie), .i_mie_mtie (mie_mtie), .i_csr_rdata (csr_rdata),
    .o_csr_addr (csr_addr), .o_csr_ren (csr_ren), .o_csr_wen (csr_wen),
    .o_csr_wdata (csr_wdata)
  );

  csr_file #(.XLEN(XLEN)) u_csr_file (
    .clk (clk), .rst (rst),
    .i_addr (csr_addr), .i_ren (csr_ren), .i_wen (csr_wen), .i_wdata (csr_wdata),
    .o_rdata (csr_rdata), .o_mstatus_mie (mstatus_mie), .o_mie_mtie (mie_mtie)
  );

endmodule

//--- tb/execute_core_tb.sv
//////////////////////////////
// runs at XLEN 64 only
// expected values are fixed in the table
//////////////////////////////

`timescale 1ns/10ps

module execute_core_tb;

  localparam int XLEN    = 64;
  localparam int max_ent = 40;

  logic               clk = 1'b0;
  logic               rst;
  logic               i_dec_req;
  exec_pkg::exec_op_e i_dec_op;
  logic [XLEN-1:0]    i_dec_pc;
  logic [XLEN-1:0]    i_dec_op1;
  logic [XLEN-1:0]    i_dec_op2;
  logic [XLEN-1:0]    i_dec_op3;
  logic [11:0]        i_dec_csr_addr;
  logic [4:0]         i_dec_rd;
  logic               i_dec_rd_wen;
  logic               i_exe_ack;
  logic               i_mtime_overflow;
  logic               o_dec_ack;
  logic               o_exe_req;
  logic [XLEN-1:0]    o_exe_pc;
  logic [4:0]         o_exe_rd;
  logic               o_exe_rd_wen;
  logic [XLEN-1:0]    o_exe_rd_wdata;
  logic               o_exe_jmp;
  logic [XLEN-1:0]    o_exe_jmp_addr;
  logic [3:0]         o_exe_intr_no;

  // stimulus and expected results per instruction
  exec_pkg::exec_op_e t_op [max_ent];
  logic [XLEN-1:0]    t_pc [max_ent];
  logic [XLEN-1:0]    t_op1 [max_ent];
  logic [XLEN-1:0]    t_op2 [max_ent];
  logic [XLEN-1:0]    t_op3 [max_ent];
  logic [11:0]        t_csr [max_ent];
  logic [4:0]         t_rd [max_ent];
  logic               t_wen [max_ent];
  logic               t_ovf [max_ent];
  logic               t_ewen [max_ent];
  logic [XLEN-1:0]    t_edata [max_ent];
  logic               t_ejmp [max_ent];
  logic [XLEN-1:0]    t_eaddr [max_ent];
  logic [3:0]         t_eintr [max_ent];

  int     n_ent       = 0;
  logic   table_ready = 1'b0;
  int     errors;
  int     checks;
  int     cur_entry;
  integer seed;

  execute_core #(.XLEN(XLEN)) i_dut (
    .clk (clk), .rst (rst),
    .i_dec_req (i_dec_req), .i_dec_op (i_dec_op), .i_dec_pc (i_dec_pc),
    .i_dec_op1 (i_dec_op1), .i_dec_op2 (i_dec_op2), .i_dec_op3 (i_dec_op3),
    .i_dec_csr_addr (i_dec_csr_addr), .i_dec_rd (i_dec_rd),
    .i_dec_rd_wen (i_dec_rd_wen), .i_exe_ack (i_exe_ack),
    .i_mtime_overflow (i_mtime_overflow),
    .o_dec_ack (o_dec_ack), .o_exe_req (o_exe_req), .o_exe_pc (o_exe_pc),
    .o_exe_rd (o_exe_rd), .o_exe_rd_wen (o_exe_rd_wen),
    .o_exe_rd_wdata (o_exe_rd_wdata), .o_exe_jmp (o_exe_jmp),
    .o_exe_jmp_addr (o_exe_jmp_addr), .o_exe_intr_no (o_exe_intr_no)
  );

  always #2 clk = ~clk;

  task automatic compare(input string what, input logic [XLEN-1:0] got,
                         input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: entry %0d %s got %h expected %h",
               $time, cur_entry, what, got, exp);
    end
  endtask

  task automatic add_entry(
    input exec_pkg::exec_op_e op,
    input logic [XLEN-1:0]    pc, op1, op2, op3,
    input logic [11:0]        csr,
    input logic               rd_wen, ovf, e_wen,
    input logic [XLEN-1:0]    e_data,
    input logic               e_jmp,
    input logic [XLEN-1:0]    e_addr,
    input logic [3:0]         e_intr
  );
    t_op[n_ent]    = op;
    t_pc[n_ent]    = pc;
    t_op1[n_ent]   = op1;
    t_op2[n_ent]   = op2;
    t_op3[n_ent]   = op3;
    t_csr[n_ent]   = csr;
    t_rd[n_ent]    = 5'(n_ent % 31 + 1);
    t_wen[n_ent]   = rd_wen;
    t_ovf[n_ent]   = ovf;
    t_ewen[n_ent]  = e_wen;
    t_edata[n_ent] = e_data;
    t_ejmp[n_ent]  = e_jmp;
    t_eaddr[n_ent] = e_addr;
    t_eintr[n_ent] = e_intr;
    n_ent++;
  endtask

  task automatic fill_table();
    // alu ops where shifts keep the low 6 bits of op2
    add_entry(exec_pkg::op_add, 'h100, 100, 23, 0, 0, 1, 0, 1, 123, 0, 0, 0);
    add_entry(exec_pkg::op_sub, 'h104, 5, 7, 0, 0, 1, 0, 1, -2, 0, 0, 0);
    add_entry(exec_pkg::op_and, 'h108, 'hf0f0, 'h0ff0, 0, 0, 1, 0, 1, 'h00f0, 0, 0, 0);
    add_entry(exec_pkg::op_or, 'h10c, 'hf000, 'h000f, 0, 0, 1, 0, 1, 'hf00f, 0, 0, 0);
    add_entry(exec_pkg::op_xor, 'h110, 'hff00, 'h0ff0, 0, 0, 1, 0, 1, 'hf0f0, 0, 0, 0);
    add_entry(exec_pkg::op_sll, 'h114, 1, 'h44, 0, 0, 1, 0, 1, 16, 0, 0, 0);
    add_entry(exec_pkg::op_srl, 'h118, 64'h8000_0000_0000_0000, 4, 0, 0, 1, 0,
              1, 64'h0800_0000_0000_0000, 0, 0, 0);
    add_entry(exec_pkg::op_sra, 'h11c, 64'h8000_0000_0000_0000, 4, 0, 0, 1, 0,
              1, 64'hf800_0000_0000_0000, 0, 0, 0);
    add_entry(exec_pkg::op_slt, 'h120, -1, 1, 0, 0, 1, 0, 1, 1, 0, 0, 0);
    add_entry(exec_pkg::op_sltu, 'h124, -1, 1, 0, 0, 1, 0, 1, 0, 0, 0, 0);
    add_entry(exec_pkg::op_nop, 'h128, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    // branches and jumps
    add_entry(exec_pkg::op_beq, 'h1000, 5, 5, 'h20, 0, 0, 0, 0, 0, 1, 'h1020, 0);
    add_entry(exec_pkg::op_bne, 'h1000, 5, 5, 'h20, 0, 0, 0, 0, 0, 0, 0, 0);
    add_entry(exec_pkg::op_blt, 'h1000, -2, 3, 'h20, 0, 0, 0, 0, 0, 1, 'h1020, 0);
    add_entry(exec_pkg::op_bge, 'h1000, -2, 3, 'h20, 0, 0, 0, 0, 0, 0, 0, 0);
    add_entry(exec_pkg::op_bge, 'h1100, 3, -2, 'h40, 0, 0, 0, 0, 0, 1, 'h1140, 0);
    add_entry(exec_pkg::op_jal, 'h2000, 'h2000, 'h100, 0, 0, 1, 0, 1, 'h2004, 1, 'h2100, 0);
    add_entry(exec_pkg::op_jalr, 'h3000, 'h4001, 'h10, 0, 0, 1, 0, 1, 'h3004, 1, 'h4010, 0);
    // csr read-modify-write returns the old value
    add_entry(exec_pkg::op_csrrw, 'h400, 'h1234_5678, 0, 0, exec_pkg::csr_mscratch,
              1, 0, 1, 0, 0, 0, 0);
    add_entry(exec_pkg::op_csrrs, 'h404, 'hf_0000, 0, 0, exec_pkg::csr_mscratch,
              1, 0, 1, 'h1234_5678, 0, 0, 0);
    add_entry(exec_pkg::op_csrrc, 'h408, 'h678, 0, 0, exec_pkg::csr_mscratch,
              1, 0, 1, 'h123f_5678, 0, 0, 0);
    add_entry(exec_pkg::op_csrrs, 'h40c, 0, 0, 0, exec_pkg::csr_mscratch,
              1, 0, 1, 'h123f_5000, 0, 0, 0);
    add_entry(exec_pkg::op_csrrw, 'h410, 'h8000, 0, 0, exec_pkg::csr_mtvec,
              1, 0, 1, 0, 0, 0, 0);
    add_entry(exec_pkg::op_csrrs, 'h414, 0, 0, 0, exec_pkg::csr_mtvec,
              1, 0, 1, 'h8000, 0, 0, 0);
    // ecall goes to mtvec and records pc and cause
    add_entry(exec_pkg::op_ecall, 'h5000, 0, 0, 0, 0, 1, 0, 0, 0, 1, 'h8000, 0);
    add_entry(exec_pkg::op_csrrs, 'h418, 0, 0, 0, exec_pkg::csr_mepc,
              1, 0, 1, 'h5000, 0, 0, 0);
    add_entry(exec_pkg::op_csrrs, 'h41c, 0, 0, 0, exec_pkg::csr_mcause,
              1, 0, 1, 11, 0, 0, 0);
    // enable the timer interrupt and let it preempt an add
    add_entry(exec_pkg::op_csrrs, 'h420, 'h80, 0, 0, exec_pkg::csr_mie,
              1, 0, 1, 0, 0, 0, 0);
    add_entry(exec_pkg::op_csrrs, 'h424, 'h8, 0, 0, exec_pkg::csr_mstatus,
              1, 0, 1, 0, 0, 0, 0);
    add_entry(exec_pkg::op_add, 'h6000, 1, 2, 0, 0, 1, 1, 0, 0, 1, 'h8000, 7);
    add_entry(exec_pkg::op_csrrs, 'h428, 0, 0, 0, exec_pkg::csr_mcause,
              1, 0, 1, 64'h8000_0000_0000_0007, 0, 0, 0);
    add_entry(exec_pkg::op_csrrs, 'h42c, 0, 0, 0, exec_pkg::csr_mepc,
              1, 0, 1, 'h6000, 0, 0, 0);
    add_entry(exec_pkg::op_csrrs, 'h430, 0, 0, 0, exec_pkg::csr_mstatus,
              1, 0, 1, 'h80, 0, 0, 0);
    add_entry(exec_pkg::op_mret, 'h9000, 0, 0, 0, 0, 0, 0, 0, 0, 1, 'h6000, 0);
    add_entry(exec_pkg::op_csrrs, 'h434, 0, 0, 0, exec_pkg::csr_mstatus,
              1, 0, 1, 'h88, 0, 0, 0);
  endtask

  task automatic check_held(input int k, input logic wen, input logic [XLEN-1:0] wdata,
                            input logic jmp, input logic [XLEN-1:0] jaddr);
    compare("exe_req held", o_exe_req, 1);
    compare("dec_ack low while pending", o_dec_ack, 0);
    compare("pc held", o_exe_pc, t_pc[k]);
    compare("rd held", o_exe_rd, t_rd[k]);
    compare("rd_wen held", o_exe_rd_wen, wen);
    compare("rd_wdata held", o_exe_rd_wdata, wdata);
    compare("jmp held", o_exe_jmp, jmp);
    compare("jmp_addr held", o_exe_jmp_addr, jaddr);
    compare("intr_no held", o_exe_intr_no, t_eintr[k]);
  endtask

  task automatic run_entry(input int k);
    int              delay;
    logic            held_wen;
    logic [XLEN-1:0] held_wdata;
    logic            held_jmp;
    logic [XLEN-1:0] held_jaddr;
    cur_entry = k;
    @(posedge clk);
    i_dec_req        <= 1'b1;
    i_dec_op         <= t_op[k];
    i_dec_pc         <= t_pc[k];
    i_dec_op1        <= t_op1[k];
    i_dec_op2        <= t_op2[k];
    i_dec_op3        <= t_op3[k];
    i_dec_csr_addr   <= t_csr[k];
    i_dec_rd         <= t_rd[k];
    i_dec_rd_wen     <= t_wen[k];
    i_mtime_overflow <= t_ovf[k];
    @(negedge clk);
    while (!o_dec_ack) begin
      @(negedge clk);
    end
    // acceptance edge
    @(posedge clk);
    i_dec_req        <= 1'b0;
    i_mtime_overflow <= 1'b0;
    @(negedge clk);
    while (!o_exe_req) begin
      compare("dec_ack low while busy", o_dec_ack, 0);
      @(negedge clk);
    end
    compare("pc", o_exe_pc, t_pc[k]);
    compare("rd", o_exe_rd, t_rd[k]);
    compare("rd_wen", o_exe_rd_wen, t_ewen[k]);
    if (t_ewen[k]) begin
      compare("rd_wdata", o_exe_rd_wdata, t_edata[k]);
    end
    compare("jmp", o_exe_jmp, t_ejmp[k]);
    if (t_ejmp[k]) begin
      compare("jmp_addr", o_exe_jmp_addr, t_eaddr[k]);
    end
    compare("intr_no", o_exe_intr_no, t_eintr[k]);
    held_wen   = o_exe_rd_wen;
    held_wdata = o_exe_rd_wdata;
    held_jmp   = o_exe_jmp;
    held_jaddr = o_exe_jmp_addr;
    // writeback back-pressure
    delay = $unsigned($random(seed)) % 4;
    repeat (delay) begin
      @(negedge clk);
      check_held(k, held_wen, held_wdata, held_jmp, held_jaddr);
    end
    @(posedge clk);
    i_exe_ack <= 1'b1;
    @(negedge clk);
    check_held(k, held_wen, held_wdata, held_jmp, held_jaddr);
    @(posedge clk);
    i_exe_ack <= 1'b0;
    @(negedge clk);
    compare("exe_req after ack", o_exe_req, 0);
    compare("dec_ack after ack", o_dec_ack, 1);
  endtask

  initial begin
    seed             = 56;
    errors           = 0;
    checks           = 0;
    cur_entry        = -1;
    rst              = 1'b1;
    i_dec_req        = 1'b0;
    i_dec_op         = exec_pkg::op_nop;
    i_dec_pc         = '0;
    i_dec_op1        = '0;
    i_dec_op2        = '0;
    i_dec_op3        = '0;
    i_dec_csr_addr   = '0;
    i_dec_rd         = '0;
    i_dec_rd_wen     = 1'b0;
    i_exe_ack        = 1'b0;
    i_mtime_overflow = 1'b0;
    fill_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    compare("exe_req after reset", o_exe_req, 0);
    compare("dec_ack after reset", o_dec_ack, 1);
    compare("jmp after reset", o_exe_jmp, 0);
    compare("rd_wen after reset", o_exe_rd_wen, 0);
    for (int k = 0; k < n_ent; k++) begin
      run_entry(k);
    end
    $display("entries: %0d, checks: %0d, errors: %0d", n_ent, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // about 12 cycles per entry at worst plus reset
  initial begin
    wait (table_ready);
    repeat (n_ent * 12 + 4) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles, stuck at entry %0d",
             n_ent * 12 + 4, cur_entry);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- execute_core.f
source/exec_pkg.sv
source/exec_unit.sv
source/trap_unit.sv
source/csr_file.sv
source/exe_stage.sv
source/execute_core.sv
tb/execute_core_tb.sv
